// File: core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data and address width
`define XLEN 32

// unique tag carried by every instruction
`define INST_ID_W 64

// data RAM depth in words
`define DMEM_WORDS 256

// wait states the RAM adds to a read after reset
`define DMEM_WAIT_DEFAULT 1

`endif

// File: core_pkg.sv
`include "core_cfg.svh"

package core_pkg;

    // one machine word, used for data and addresses
    typedef logic [`XLEN-1:0] word_t;

    // per-instruction tag, lets a stage tell a held instruction from a new one
    typedef logic [`INST_ID_W-1:0] inst_id_t;

    // memory operation of an instruction
    typedef enum logic [3:0] {
        MEM_X,
        MEM_LB,
        MEM_LBU,
        MEM_LH,
        MEM_LHU,
        MEM_LW,
        MEM_SB,
        MEM_SH,
        MEM_SW,
        MEM_AMOSWAP_W
    } mem_op_t;

    // memory-side control of an instruction
    typedef struct packed {
        mem_op_t mem_op;
        word_t   rs2_data;
    } mem_ctrl_t;

    // instruction record as handed from execute to memory and on to writeback
    typedef struct packed {
        word_t     reg_pc;
        word_t     inst;
        inst_id_t  inst_id;
        mem_ctrl_t ctrl;
        // effective address for loads and stores
        word_t     alu_out;
    } mem_inst_t;

endpackage

// File: dmem_pkg.sv
`include "core_cfg.svh"

package dmem_pkg;

    // word index into the data RAM
    typedef logic [$clog2(`DMEM_WORDS)-1:0] dmem_index_t;

    // request from the memory stage, transfers when valid and ready are both high
    typedef struct packed {
        logic            valid;
        logic            wen;
        core_pkg::word_t addr;
        core_pkg::word_t wdata;
        // one bit per data bit
        core_pkg::word_t wmask;
    } dmem_req_t;

    // ready for the request side, valid is a one-cycle read-data pulse
    typedef struct packed {
        logic            ready;
        logic            valid;
        core_pkg::word_t rdata;
    } dmem_resp_t;

endpackage

// File: memory_stage.sv
`timescale 1ns/1ps

module memory_stage
    import core_pkg::*;
    import dmem_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       mem_valid,
    input  mem_inst_t  mem_in,
    input  logic       pipeline_flush,
    output dmem_req_t  dreq,
    input  dmem_resp_t dresp,
    output logic       mem_wb_valid,
    output mem_inst_t  wb_out,
    output word_t      mem_wb_rdata,
    output logic       memory_unit_stall
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_READY,
        ST_WAIT_RDATA
    } stage_state_t;

    stage_state_t state;
    mem_op_t      cur_op;
    mem_op_t      op;
    inst_id_t     seen_id;
    logic         seen_valid;
    logic         new_inst;
    logic         is_store;
    logic         drop_rsp;
    logic [1:0]   byte_off;
    word_t        rdata_q;

    assign byte_off = mem_in.alu_out[1:0];

    // an id other than the last one seen marks a fresh instruction
    assign new_inst = mem_valid && (!seen_valid || seen_id != mem_in.inst_id);

    // the latched op takes over after the first cycle so a swap can become its store
    always_comb begin
        if (!mem_valid)
            op = MEM_X;
        else if (new_inst)
            op = mem_in.ctrl.mem_op;
        else
            op = cur_op;
    end

    assign is_store = (op == MEM_SB) || (op == MEM_SH) || (op == MEM_SW);

    // request with store data moved into its byte lanes
    always_comb begin
        dreq.valid = mem_valid && !pipeline_flush && (state == ST_WAIT_READY);
        dreq.wen   = is_store;
        dreq.addr  = mem_in.alu_out;
        case (op)
            MEM_SB: begin
                dreq.wmask = word_t'('hff) << {byte_off, 3'b000};
                dreq.wdata = mem_in.ctrl.rs2_data << {byte_off, 3'b000};
            end
            MEM_SH: begin
                dreq.wmask = word_t'('hffff) << {byte_off[1], 4'b0000};
                dreq.wdata = mem_in.ctrl.rs2_data << {byte_off[1], 4'b0000};
            end
            default: begin
                dreq.wmask = '1;
                dreq.wdata = mem_in.ctrl.rs2_data;
            end
        endcase
    end

    // pick the addressed byte or half and extend it
    function automatic word_t load_extend(
        input mem_op_t    ld_op,
        input logic [1:0] off,
        input word_t      raw
    );
        word_t byte_lane;
        word_t half_lane;
        byte_lane = raw >> {off, 3'b000};
        half_lane = raw >> {off[1], 4'b0000};
        case (ld_op)
            MEM_LB:  load_extend = {{($bits(word_t) - 8){byte_lane[7]}}, byte_lane[7:0]};
            MEM_LBU: load_extend = {{($bits(word_t) - 8){1'b0}}, byte_lane[7:0]};
            MEM_LH:  load_extend = {{($bits(word_t) - 16){half_lane[15]}}, half_lane[15:0]};
            MEM_LHU: load_extend = {{($bits(word_t) - 16){1'b0}}, half_lane[15:0]};
            // LW and the old word of a swap
            default: load_extend = raw;
        endcase
    endfunction

    assign memory_unit_stall = mem_valid && (state != ST_IDLE || op != MEM_X);

    assign mem_wb_valid = mem_valid && !memory_unit_stall && !pipeline_flush;
    assign wb_out       = mem_in;
    assign mem_wb_rdata = load_extend(mem_in.ctrl.mem_op, byte_off, rdata_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            cur_op     <= MEM_X;
            seen_valid <= 1'b0;
        end else if (pipeline_flush || !mem_valid) begin
            // a flushed instruction that stays on the input starts over
            state      <= ST_IDLE;
            cur_op     <= MEM_X;
            seen_valid <= 1'b0;
        end else begin
            seen_valid <= 1'b1;
            case (state)
                ST_IDLE: begin
                    cur_op <= op;
                    if (op != MEM_X)
                        state <= ST_WAIT_READY;
                end
                ST_WAIT_READY: begin
                    if (dresp.ready) begin
                        if (is_store) begin
                            state  <= ST_IDLE;
                            cur_op <= MEM_X;
                        end else begin
                            state <= ST_WAIT_RDATA;
                        end
                    end
                end
                ST_WAIT_RDATA: begin
                    if (dresp.valid) begin
                        if (cur_op == MEM_AMOSWAP_W) begin
                            // second half of the swap writes rs2_data back
                            state  <= ST_WAIT_READY;
                            cur_op <= MEM_SW;
                        end else begin
                            state  <= ST_IDLE;
                            cur_op <= MEM_X;
                        end
                    end
                end
                default: begin
                    state  <= ST_IDLE;
                    cur_op <= MEM_X;
                end
            endcase
        end
    end

    // read left behind by a flush that the RAM still answers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            drop_rsp <= 1'b0;
        else if (dresp.valid)
            drop_rsp <= 1'b0;
        else if ((pipeline_flush || !mem_valid) && state == ST_WAIT_RDATA)
            drop_rsp <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (mem_valid)
            seen_id <= mem_in.inst_id;
        if (state == ST_WAIT_RDATA && dresp.valid)
            rdata_q <= dresp.rdata;
    end

    // a request not yet taken keeps its payload unless it is withdrawn
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        dreq.valid && !dresp.ready |=> pipeline_flush || !mem_valid || $stable(dreq))
        else $error("memory_stage: dreq changed before transfer");

    // responses only arrive for a read this stage is waiting on or has dropped
    a_no_rsp_idle: assert property (@(posedge clk) disable iff (!rst_n)
        state == ST_IDLE && !drop_rsp |-> !dresp.valid)
        else $error("memory_stage: dresp.valid in idle");

endmodule

// File: data_ram.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module data_ram
    import core_pkg::*;
    import dmem_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  dmem_req_t  dreq,
    output dmem_resp_t dresp,
    input  logic [3:0] wait_states,
    output logic       load_done,
    output logic       store_done
);

    word_t       mem [`DMEM_WORDS];
    dmem_index_t idx;
    logic        busy;
    logic [3:0]  wait_cnt;
    logic        rd_xfer;
    logic        wr_xfer;
    word_t       rdata_q;

    // the two low address bits only select a byte lane
    assign idx = dreq.addr[2 +: $bits(dmem_index_t)];

    assign rd_xfer = dreq.valid && !busy && !dreq.wen;
    assign wr_xfer = dreq.valid && !busy && dreq.wen;

    always_comb begin
        dresp.ready = !busy;
        dresp.valid = busy && (wait_cnt == '0);
        dresp.rdata = rdata_q;
    end

    assign load_done  = dresp.valid;
    assign store_done = wr_xfer;

    // pending read counts down the wait states latched at the transfer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            wait_cnt <= '0;
        end else if (rd_xfer) begin
            busy     <= 1'b1;
            wait_cnt <= wait_states;
        end else if (busy) begin
            if (wait_cnt == '0)
                busy <= 1'b0;
            else
                wait_cnt <= wait_cnt - 1'b1;
        end
    end

    // array and read word
    always_ff @(posedge clk) begin
        if (wr_xfer)
            mem[idx] <= (mem[idx] & ~dreq.wmask) | (dreq.wdata & dreq.wmask);
        if (rd_xfer)
            rdata_q <= mem[idx];
    end

endmodule

// File: dmem_latency_regs.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module dmem_latency_regs
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cfg_we,
    input  logic [1:0] cfg_addr,
    input  word_t      cfg_wdata,
    output word_t      cfg_rdata,
    input  logic       load_done,
    input  logic       store_done,
    output logic [3:0] wait_states
);

    localparam logic [1:0] REG_WAIT   = 2'd0;
    localparam logic [1:0] REG_LOADS  = 2'd1;
    localparam logic [1:0] REG_STORES = 2'd2;
    localparam logic [1:0] REG_CLEAR  = 2'd3;

    word_t load_cnt;
    word_t store_cnt;
    logic  clear;

    assign clear = cfg_we && (cfg_addr == REG_CLEAR);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wait_states <= 4'(`DMEM_WAIT_DEFAULT);
        else if (cfg_we && cfg_addr == REG_WAIT)
            wait_states <= cfg_wdata[3:0];
    end

    // traffic counters stop at all ones, clear wins over a count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_cnt  <= '0;
            store_cnt <= '0;
        end else if (clear) begin
            load_cnt  <= '0;
            store_cnt <= '0;
        end else begin
            if (load_done && load_cnt != '1)
                load_cnt <= load_cnt + 1'b1;
            if (store_done && store_cnt != '1)
                store_cnt <= store_cnt + 1'b1;
        end
    end

    always_comb begin
        case (cfg_addr)
            REG_WAIT:   cfg_rdata = word_t'(wait_states);
            REG_LOADS:  cfg_rdata = load_cnt;
            REG_STORES: cfg_rdata = store_cnt;
            default:    cfg_rdata = '0;
        endcase
    end

endmodule

// File: mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top
    import core_pkg::*;
    import dmem_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       mem_valid,
    input  mem_inst_t  mem_in,
    input  logic       pipeline_flush,
    input  logic       cfg_we,
    input  logic [1:0] cfg_addr,
    input  word_t      cfg_wdata,
    output logic       mem_wb_valid,
    output mem_inst_t  wb_out,
    output word_t      mem_wb_rdata,
    output logic       memory_unit_stall,
    output word_t      cfg_rdata
);

    dmem_req_t  dreq;
    dmem_resp_t dresp;
    logic [3:0] wait_states;
    logic       load_done;
    logic       store_done;

    memory_stage u_stage (
        .clk               (clk),
        .rst_n             (rst_n),
        .mem_valid         (mem_valid),
        .mem_in            (mem_in),
        .pipeline_flush    (pipeline_flush),
        .dreq              (dreq),
        .dresp             (dresp),
        .mem_wb_valid      (mem_wb_valid),
        .wb_out            (wb_out),
        .mem_wb_rdata      (mem_wb_rdata),
        .memory_unit_stall (memory_unit_stall)
    );

    data_ram u_ram (
        .clk         (clk),
        .rst_n       (rst_n),
        .dreq        (dreq),
        .dresp       (dresp),
        .wait_states (wait_states),
        .load_done   (load_done),
        .store_done  (store_done)
    );

    // wait states and access counters for the RAM
    dmem_latency_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata),
        .load_done   (load_done),
        .store_done  (store_done),
        .wait_states (wait_states)
    );

endmodule

// File: tb_mem_subsystem.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module tb_mem_subsystem
    import core_pkg::*;
    import dmem_pkg::*;
;

    localparam int WB_TIMEOUT = 100;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       mem_valid;
    mem_inst_t  mem_in;
    logic       pipeline_flush;
    logic       cfg_we;
    logic [1:0] cfg_addr;
    word_t      cfg_wdata;
    logic       mem_wb_valid;
    mem_inst_t  wb_out;
    word_t      mem_wb_rdata;
    logic       memory_unit_stall;
    word_t      cfg_rdata;

    // expectations driven alongside the stimulus
    logic       chk_load;
    word_t      exp_rdata;
    logic       arriving;
    logic       chk_cfg;
    word_t      exp_cfg;
    inst_id_t   flushed_id;

    word_t      shadow [`DMEM_WORDS];
    word_t      lcg_state;
    inst_id_t   next_id;
    int         cur_ws;
    int         n_loads;
    int         n_stores;

    mem_subsystem_top u_dut (.*);

    always #2 clk = ~clk;

    task automatic stop_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string sig, input word_t exp_v, input word_t got_v);
        $display("[FAIL] time %0t: %s expected %h actual %h", $time, sig, exp_v, got_v);
        stop_run();
    endtask

    task automatic abort_run(input string why);
        $display("error at time %0t: %s", $time, why);
        stop_run();
    endtask

    a_load_data: assert property (@(posedge clk) disable iff (!rst_n)
        mem_wb_valid && chk_load |-> mem_wb_rdata == exp_rdata)
        else report_mismatch("mem_wb_rdata", $sampled(exp_rdata), $sampled(mem_wb_rdata));

    a_cfg_read: assert property (@(posedge clk) disable iff (!rst_n)
        chk_cfg |-> cfg_rdata == exp_cfg)
        else report_mismatch("cfg_rdata", $sampled(exp_cfg), $sampled(cfg_rdata));

    a_stall_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !mem_valid |-> !memory_unit_stall)
        else abort_run("memory_unit_stall is high while mem_valid is low");

    a_stall_arrive: assert property (@(posedge clk) disable iff (!rst_n)
        arriving |-> memory_unit_stall)
        else abort_run("memory_unit_stall is low in the cycle an access arrived");

    a_flushed_wb: assert property (@(posedge clk) disable iff (!rst_n)
        mem_wb_valid |-> wb_out.inst_id != flushed_id)
        else abort_run("a flushed instruction reached writeback");

    // the instruction record reaches writeback unchanged
    a_wb_pass: assert property (@(posedge clk) disable iff (!rst_n)
        mem_wb_valid |-> wb_out == mem_in)
        else begin
            $display("[FAIL] time %0t: wb_out expected %h actual %h",
                     $time, $sampled(mem_in), $sampled(wb_out));
            stop_run();
        end

    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // word aligned inside the RAM
    function automatic word_t rand_addr();
        return (next_rand() >> 4) & 32'h3fc;
    endfunction

    function automatic word_t expect_load(input mem_op_t op, input word_t addr);
        word_t      w;
        logic [7:0]  b;
        logic [15:0] h;
        w = shadow[dmem_index_t'(addr >> 2)];
        b = w[8 * addr[1:0] +: 8];
        h = w[16 * addr[1] +: 16];
        case (op)
            MEM_LB:  return {{24{b[7]}}, b};
            MEM_LBU: return {24'h0, b};
            MEM_LH:  return {{16{h[15]}}, h};
            MEM_LHU: return {16'h0, h};
            default: return w;
        endcase
    endfunction

    function automatic void update_shadow(input mem_op_t op, input word_t addr, input word_t data);
        dmem_index_t i;
        i = dmem_index_t'(addr >> 2);
        case (op)
            MEM_SB:  shadow[i][8 * addr[1:0] +: 8] = data[7:0];
            MEM_SH:  shadow[i][16 * addr[1] +: 16] = data[15:0];
            default: shadow[i] = data;
        endcase
    endfunction

    function automatic mem_inst_t make_inst(input mem_op_t op, input word_t addr, input word_t data);
        mem_inst_t rec;
        next_id = next_id + 1;
        rec.reg_pc        = word_t'(next_id << 2);
        rec.inst          = '0;
        rec.inst_id       = next_id;
        rec.ctrl.mem_op   = op;
        rec.ctrl.rs2_data = data;
        rec.alu_out       = addr;
        return rec;
    endfunction

    // drive one instruction and hold it until writeback takes it
    task automatic send(input mem_op_t op, input word_t addr, input word_t data,
                        input logic check, input word_t exp, input int lat);
        mem_inst_t rec;
        int        cnt;
        rec = make_inst(op, addr, data);
        @(posedge clk);
        mem_valid <= 1'b1;
        mem_in    <= rec;
        chk_load  <= check;
        exp_rdata <= exp;
        arriving  <= 1'b1;
        @(posedge clk);
        arriving <= 1'b0;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
            if (cnt > WB_TIMEOUT)
                abort_run("no writeback before the timeout");
        end while (!mem_wb_valid);
        // cycles from arrival to writeback
        assert (cnt == lat) else report_mismatch("stall cycles", word_t'(lat), word_t'(cnt));
    endtask

    task automatic store_data(input mem_op_t op, input word_t addr, input word_t data);
        send(op, addr, data, 1'b0, '0, 2);
        update_shadow(op, addr, data);
        n_stores++;
    endtask

    task automatic load_and_check(input mem_op_t op, input word_t addr);
        send(op, addr, next_rand(), 1'b1, expect_load(op, addr), cur_ws + 3);
        n_loads++;
    endtask

    task automatic swap_and_check(input word_t addr, input word_t data);
        send(MEM_AMOSWAP_W, addr, data, 1'b1, expect_load(MEM_LW, addr), cur_ws + 4);
        update_shadow(MEM_SW, addr, data);
        n_loads++;
        n_stores++;
    endtask

    // load dropped by a flush while its read is pending
    task automatic flush_load(input word_t addr);
        mem_inst_t rec;
        rec = make_inst(MEM_LW, addr, '0);
        @(posedge clk);
        mem_valid  <= 1'b1;
        mem_in     <= rec;
        chk_load   <= 1'b0;
        arriving   <= 1'b1;
        flushed_id <= rec.inst_id;
        @(posedge clk);
        arriving <= 1'b0;
        repeat (2) @(posedge clk);
        // flush covers the read response while the instruction stays on the input
        pipeline_flush <= 1'b1;
        repeat (cur_ws + 1) @(posedge clk);
        pipeline_flush <= 1'b0;
        @(posedge clk);
        mem_valid <= 1'b0;
        n_loads++;
    endtask

    task automatic write_cfg(input logic [1:0] addr, input word_t data);
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_we <= 1'b0;
    endtask

    task automatic check_cfg(input logic [1:0] addr, input word_t exp);
        @(posedge clk);
        cfg_addr <= addr;
        chk_cfg  <= 1'b1;
        exp_cfg  <= exp;
        @(posedge clk);
        chk_cfg <= 1'b0;
    endtask

    task automatic set_wait(input int ws);
        write_cfg(2'd0, word_t'(ws));
        cur_ws = ws;
        check_cfg(2'd0, word_t'(ws));
    endtask

    initial begin
        word_t a;
        rst_n = 1'b0;
        mem_valid = 1'b0;
        mem_in = '0;
        pipeline_flush = 1'b0;
        cfg_we = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        chk_load = 1'b0;
        exp_rdata = '0;
        arriving = 1'b0;
        chk_cfg = 1'b0;
        exp_cfg = '0;
        flushed_id = '1;
        lcg_state = 32'd3736;
        next_id = '0;
        cur_ws = `DMEM_WAIT_DEFAULT;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        check_cfg(2'd0, `DMEM_WAIT_DEFAULT);
        check_cfg(2'd1, '0);
        check_cfg(2'd2, '0);

        // every word gets a known value first
        for (int i = 0; i < `DMEM_WORDS; i++)
            store_data(MEM_SW, word_t'(i << 2), next_rand());
        write_cfg(2'd3, '0);
        n_loads = 0;
        n_stores = 0;

        repeat (20) begin
            a = rand_addr();
            store_data(MEM_SW, a, next_rand());
            load_and_check(MEM_LW, a);
        end

        // byte and half lanes at every offset
        repeat (6) begin
            a = rand_addr();
            for (int off = 0; off < 4; off++) begin
                store_data(MEM_SB, a + off, next_rand());
                load_and_check(MEM_LW, a);
                load_and_check(MEM_LB, a + off);
                load_and_check(MEM_LBU, a + off);
            end
            for (int off = 0; off < 4; off += 2) begin
                store_data(MEM_SH, a + off, next_rand());
                load_and_check(MEM_LW, a);
                load_and_check(MEM_LH, a + off);
                load_and_check(MEM_LHU, a + off);
            end
        end

        repeat (8) begin
            a = rand_addr();
            swap_and_check(a, next_rand());
            load_and_check(MEM_LW, a);
        end
        check_cfg(2'd1, word_t'(n_loads));
        check_cfg(2'd2, word_t'(n_stores));

        repeat (6) begin
            set_wait(int'(next_rand() >> 28));
            repeat (4) begin
                load_and_check(MEM_LW, rand_addr());
                load_and_check(MEM_LB, rand_addr() + (next_rand() >> 30));
            end
            swap_and_check(rand_addr(), next_rand());
        end

        // slow RAM so the flush lands while the read is pending
        set_wait(8);
        write_cfg(2'd3, '0);
        n_loads = 0;
        n_stores = 0;
        flush_load(rand_addr());
        load_and_check(MEM_LW, rand_addr());
        store_data(MEM_SW, rand_addr(), next_rand());
        swap_and_check(rand_addr(), next_rand());
        check_cfg(2'd1, word_t'(n_loads));
        check_cfg(2'd2, word_t'(n_stores));

        $display("Done: no errors");
        $finish;
    end

endmodule

// File: files.f
+incdir+.
core_pkg.sv
dmem_pkg.sv
memory_stage.sv
data_ram.sv
dmem_latency_regs.sv
mem_subsystem_top.sv
tb_mem_subsystem.sv
